// File: tests/ahb_master_golden.txt
// addr burst size write wdata_seed waits err_beat kind (all hex)
// kind 0 ok, 1 HRESP error on err_beat, 2 HREADY timeout, 3 rejected command
00000010 0 2 1 1234abcd 0 0 0
00000010 0 2 0 00000000 0 0 0
00000020 3 2 1 0badf00d 1 0 0
00000020 3 2 0 00000000 0 0 0
00000040 5 2 1 13572468 2 0 0
00000040 5 2 0 00000000 1 0 0
00000080 7 2 0 00000000 0 0 0
0000000c 3 1 0 00000000 0 0 0
00000038 2 2 1 cafe0001 0 0 0
00000038 2 2 0 00000000 0 0 0
00000054 4 2 0 00000000 1 0 0
000000c8 6 2 1 feed0002 3 0 0
000000c8 6 2 0 00000000 1 0 0
00000020 3 2 1 77770003 5 0 0
00000020 3 2 0 00000000 5 0 0
00000020 3 2 0 00000000 6 0 2
00000060 5 2 1 abab0004 0 2 1
00000060 5 2 0 00000000 0 0 0
00000030 3 2 0 00000000 2 3 1
00000008 0 2 0 00000000 0 0 1
00000002 0 2 0 00000000 0 0 3
00000000 0 3 0 00000000 0 0 3
000003f8 3 2 0 00000000 0 0 3
00000010 0 2 0 00000000 0 0 0

// File: filelist.f
logic/ahb_master_pkg.sv
logic/ahb_req_check.sv
logic/ahb_master_fsm.sv
logic/ahb_beat_counter.sv
logic/ahb_addr_gen.sv
logic/ahb_data_path.sv
logic/ahb_master_top.sv
tests/ahb_master_properties.sv
tests/ahb_master_tb.sv

// File: tests/ahb_master_tb.sv
`timescale 1ns/1ns
// testbench for the AHB-Lite master with a behavioral slave driven by a golden command list
module ahb_master_tb import ahb_master_pkg::*; ();

    localparam int MAX_CMDS     = 32;
    localparam int CMD_LIMIT    = 200;
    localparam int KIND_OK      = 0;
    localparam int KIND_BUS_ERR = 1;
    localparam int KIND_TIMEOUT = 2;
    localparam int KIND_REJECT  = 3;

    logic      ahb_clk_in;
    logic      ahb_rstn_in;
    ahb_cmd_t  cmd;
    ahb_cmd_t  next_cmd;
    logic      cmd_valid;
    logic      cmd_ready;
    data_t     wdata;
    logic      beat_pop;
    ahb_rsp_t  rsp;
    logic      rsp_valid;
    ahb_ctrl_t ctrl;
    data_t     hwdata;
    data_t     hrdata;
    logic      hready;
    logic      hresp;

    logic [31:0] gold [0:MAX_CMDS*8-1];
    data_t       mem [0:63];
    addr_t       exp_addr [0:15];
    data_t       wbeat [0:15];
    ahb_rsp_t    exp_rsp_q [$];

    // command under test and the slave's view of its outstanding data phase
    int         nbeats;
    int         kind;
    int         err_beat;
    int         waits;
    int         aidx;
    int         low_cnt;
    int         wait_left;
    int         rsp_seen;
    int         pend_beat;
    logic       active;
    logic       stopped;
    logic       pend_valid;
    logic       pend_write;
    logic [5:0] pend_idx;

    ahb_master_top i_dut (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .wdata       (wdata),
        .beat_pop    (beat_pop),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .ctrl        (ctrl),
        .hwdata      (hwdata),
        .hrdata      (hrdata),
        .hready      (hready),
        .hresp       (hresp)
    );

    initial begin
        ahb_clk_in = 1'b0;
        forever #50 ahb_clk_in = ~ahb_clk_in;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_assertions();
        if (i_dut.i_props.assert_failed) begin
            fail_now("a bound protocol assertion failed");
        end
    endtask

    task automatic check_ctrl(input string name, input ahb_ctrl_t got, input ahb_ctrl_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_rsp(input string name, input ahb_rsp_t got, input ahb_rsp_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED t=%0t %s got=%h expected=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("FAILED t=%0t %s got=%b expected=%b", $time, name, got, exp));
        end
    endtask

    function automatic int burst_len(input burst_e burst);
        case (burst)
            BURST_WRAP4, BURST_INCR4:   return 4;
            BURST_WRAP8, BURST_INCR8:   return 8;
            BURST_WRAP16, BURST_INCR16: return 16;
            default:                    return 1;
        endcase
    endfunction

    // a wrapping burst stays inside an aligned block of beats times size bytes
    function automatic addr_t next_beat_addr(input addr_t a, input burst_e b, input size_e s,
                                             input int beats);
        int unsigned step;
        int unsigned block;
        addr_t       base;
        step  = 1 << s;
        block = step * beats;
        if ((b == BURST_WRAP4) || (b == BURST_WRAP8) || (b == BURST_WRAP16)) begin
            base = a - (a % block);
            return base + ((a - base + step) % block);
        end
        return a + step;
    endfunction

    task automatic observe(input logic present);
        ahb_ctrl_t exp_ctrl;
        int        idx;
        logic      take;
        check_bit("rsp_valid", rsp_valid, exp_rsp_q.size() != 0);
        if (rsp_valid) begin
            check_rsp("rsp", rsp, exp_rsp_q.pop_front());
            rsp_seen++;
        end
        if (present) begin
            check_bit("cmd_ready", cmd_ready, 1'b1);
            check_bit("beat_pop", beat_pop, 1'b0);
            active = 1'b1;
            if (kind == KIND_REJECT) begin
                exp_rsp_q.push_back('{rdata: '0, error: 1'b1, timeout: 1'b0});
                stopped = 1'b1;
            end
        end else if (active) begin
            if (kind == KIND_REJECT) begin
                check_bit("htrans_is_idle", ctrl.htrans == TRANS_IDLE, 1'b1);
            end else begin
                idx = (aidx < nbeats) ? aidx : nbeats - 1;
                exp_ctrl.haddr  = exp_addr[idx];
                exp_ctrl.hburst = cmd.burst;
                exp_ctrl.hsize  = cmd.size;
                exp_ctrl.hwrite = cmd.write;
                if (stopped || (aidx >= nbeats)) begin
                    exp_ctrl.htrans = TRANS_IDLE;
                end else begin
                    exp_ctrl.htrans = (aidx == 0) ? TRANS_NONSEQ : TRANS_SEQ;
                end
                check_ctrl("ctrl", ctrl, exp_ctrl);
            end
            if (pend_valid) begin
                if (pend_write) begin
                    check_data("hwdata", hwdata, wbeat[pend_beat]);
                end
                if (hready) begin
                    exp_rsp_q.push_back('{rdata: pend_write ? '0 : mem[pend_idx],
                                          error: hresp, timeout: 1'b0});
                    if (pend_write && !hresp) begin
                        mem[pend_idx] = wbeat[pend_beat];
                    end
                    stopped    = stopped || hresp;
                    pend_valid = 1'b0;
                end else begin
                    low_cnt++;
                    wait_left--;
                    if (low_cnt == WAIT_TIMEOUT) begin
                        exp_rsp_q.push_back('{rdata: '0, error: 1'b1, timeout: 1'b1});
                        stopped    = 1'b1;
                        pend_valid = 1'b0;
                    end
                end
            end
            take = !stopped && (aidx < nbeats) && hready;
            check_bit("beat_pop", beat_pop, take);
            if (take) begin
                pend_valid = 1'b1;
                pend_beat  = aidx;
                pend_idx   = exp_addr[aidx][7:2];
                pend_write = cmd.write;
                wait_left  = waits;
                low_cnt    = 0;
                aidx++;
            end
        end
    endtask

    // the slave answers on the falling edge and everything is judged on the rising edge
    task automatic drive_and_sample(input logic present);
        @(negedge ahb_clk_in);
        check_assertions();
        if (present) begin
            cmd = next_cmd;
        end
        cmd_valid = present;
        hready    = !(pend_valid && (wait_left != 0));
        hresp     = pend_valid && hready && (kind == KIND_BUS_ERR) && (pend_beat == err_beat);
        hrdata    = (pend_valid && !pend_write) ? mem[pend_idx] : '0;
        wdata     = (active && cmd.write && (aidx < nbeats)) ? wbeat[aidx] : '0;
        @(posedge ahb_clk_in);
        observe(present);
    endtask

    task automatic run_command(input int c);
        int base;
        int cycles;
        int exp_count;
        int exp_pops;
        base     = c * 8;
        next_cmd = '{addr: gold[base], burst: burst_e'(gold[base+1][2:0]),
                     size: size_e'(gold[base+2][2:0]), write: gold[base+3][0]};
        waits    = gold[base+5];
        err_beat = gold[base+6];
        kind     = gold[base+7];
        nbeats   = burst_len(next_cmd.burst);
        exp_addr[0] = next_cmd.addr;
        for (int b = 1; b < nbeats; b++) begin
            exp_addr[b] = next_beat_addr(exp_addr[b-1], next_cmd.burst, next_cmd.size, nbeats);
        end
        for (int b = 0; b < nbeats; b++) begin
            wbeat[b] = $urandom() ^ gold[base+4];
        end
        case (kind)
            KIND_OK:      exp_count = nbeats;
            KIND_BUS_ERR: exp_count = err_beat + 1;
            default:      exp_count = 1;
        endcase
        exp_pops   = (kind == KIND_REJECT) ? 0 : ((kind == KIND_TIMEOUT) ? 1 : exp_count);
        aidx       = 0;
        rsp_seen   = 0;
        low_cnt    = 0;
        wait_left  = 0;
        active     = 1'b0;
        stopped    = 1'b0;
        pend_valid = 1'b0;
        drive_and_sample(1'b1);
        cycles = 0;
        while (!((rsp_seen == exp_count) && cmd_ready && !pend_valid)) begin
            if (cycles == CMD_LIMIT) begin
                fail_now($sformatf("command %0d did not finish within %0d cycles", c, CMD_LIMIT));
            end else begin
                drive_and_sample(1'b0);
                cycles++;
            end
        end
        if (aidx != exp_pops) begin
            fail_now($sformatf("command %0d completed %0d address phases instead of %0d",
                               c, aidx, exp_pops));
        end else if (exp_rsp_q.size() != 0) begin
            fail_now($sformatf("command %0d ended with responses still missing", c));
        end
    endtask

    initial begin
        int c;
        ahb_rstn_in = 1'b0;
        cmd         = '0;
        next_cmd    = '0;
        cmd_valid   = 1'b0;
        wdata       = '0;
        hrdata      = '0;
        hready      = 1'b1;
        hresp       = 1'b0;
        kind        = KIND_OK;
        active      = 1'b0;
        pend_valid  = 1'b0;
        void'($urandom(41));
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i << 10) ^ (i * 3);
        end
        for (int i = 0; i < MAX_CMDS * 8; i++) begin
            gold[i] = '1;
        end
        $readmemh("tests/ahb_master_golden.txt", gold);
        repeat (5) @(posedge ahb_clk_in);
        check_bit("cmd_ready", cmd_ready, 1'b1);
        check_bit("beat_pop", beat_pop, 1'b0);
        check_bit("rsp_valid", rsp_valid, 1'b0);
        check_bit("htrans_is_idle", ctrl.htrans == TRANS_IDLE, 1'b1);
        check_data("hwdata", hwdata, '0);
        @(negedge ahb_clk_in);
        ahb_rstn_in = 1'b1;
        c = 0;
        while ((c < MAX_CMDS) && (gold[c*8+7] !== 32'hffff_ffff)) begin
            run_command(c);
            c++;
        end
        @(negedge ahb_clk_in);
        if (c == 0) begin
            fail_now("no commands were read from the golden file");
        end else if (i_dut.i_props.assert_failed) begin
            fail_now("a bound protocol assertion failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: tests/ahb_master_properties.sv
`timescale 1ns/1ns
// AHB protocol assertions bound into the master top level
module ahb_master_properties import ahb_master_pkg::*; (
    input logic      ahb_clk_in,
    input logic      ahb_rstn_in,
    input ahb_ctrl_t ctrl,
    input logic      hready,
    input logic      hresp,
    input logic      cmd_valid,
    input logic      cmd_ready,
    input logic      rsp_valid,
    input logic      abort_timeout
);
    logic dphase;
    logic assert_failed;

    initial begin
        assert_failed = 1'b0;
    end

    // a data phase follows every accepted address phase unless an error response cancelled it
    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            dphase <= 1'b0;
        end else if (hready) begin
            dphase <= ((ctrl.htrans == TRANS_NONSEQ) || (ctrl.htrans == TRANS_SEQ)) &&
                      !(dphase && hresp);
        end
    end

    // a stalled address phase stays on the bus until the timeout gives up on it
    ctrl_stable_a: assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        ((ctrl.htrans != TRANS_IDLE) && !hready && !abort_timeout) |=> $stable(ctrl))
        else begin
            $error("address phase controls changed while HREADY was low");
            assert_failed = 1'b1;
        end

    seq_order_a: assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        (ctrl.htrans == TRANS_SEQ) |->
            (($past(ctrl.htrans) == TRANS_NONSEQ) || ($past(ctrl.htrans) == TRANS_SEQ)))
        else begin
            $error("SEQ transfer without a preceding NONSEQ or SEQ");
            assert_failed = 1'b1;
        end

    // a timeout or a rejected command answers with the bus already idle
    rsp_cause_a: assert property (@(posedge ahb_clk_in) disable iff (!ahb_rstn_in)
        rsp_valid |-> ($past(dphase && hready) ||
                       ((ctrl.htrans == TRANS_IDLE) &&
                        $past((dphase && !hready) || (cmd_valid && cmd_ready)))))
        else begin
            $error("client response without an ended data phase, timeout or rejection");
            assert_failed = 1'b1;
        end

endmodule

bind ahb_master_top ahb_master_properties i_props (
    .ahb_clk_in    (ahb_clk_in),
    .ahb_rstn_in   (ahb_rstn_in),
    .ctrl          (ctrl),
    .hready        (hready),
    .hresp         (hresp),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .rsp_valid     (rsp_valid),
    .abort_timeout (abort_timeout)
);

// File: logic/ahb_master_top.sv
`timescale 1ns/1ns
// AHB-Lite master top level joining command check, sequencing FSM, counters, address and data paths
module ahb_master_top import ahb_master_pkg::*; (
    input  logic      ahb_clk_in,
    input  logic      ahb_rstn_in,
    input  ahb_cmd_t  cmd,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  data_t     wdata,
    output logic      beat_pop,
    output ahb_rsp_t  rsp,
    output logic      rsp_valid,
    output ahb_ctrl_t ctrl,
    output data_t     hwdata,
    input  data_t     hrdata,
    input  logic      hready,
    input  logic      hresp
);
    logic cmd_ok;
    logic load;
    logic advance;
    logic go_idle;
    logic addr_done;
    logic data_busy;
    logic last_beat;
    logic timed_out;
    logic phase_done;
    logic abort_err;
    logic abort_timeout;
    logic reject;

    ahb_req_check i_req_check (
        .cmd    (cmd),
        .cmd_ok (cmd_ok)
    );

    ahb_master_fsm i_fsm (
        .ahb_clk_in    (ahb_clk_in),
        .ahb_rstn_in   (ahb_rstn_in),
        .cmd_valid     (cmd_valid),
        .cmd_ok        (cmd_ok),
        .hready        (hready),
        .hresp         (hresp),
        .htrans        (ctrl.htrans),
        .last_beat     (last_beat),
        .timed_out     (timed_out),
        .cmd_ready     (cmd_ready),
        .beat_pop      (beat_pop),
        .load          (load),
        .advance       (advance),
        .go_idle       (go_idle),
        .addr_done     (addr_done),
        .data_busy     (data_busy),
        .phase_done    (phase_done),
        .abort_err     (abort_err),
        .abort_timeout (abort_timeout),
        .reject        (reject)
    );

    ahb_beat_counter i_beat_counter (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .load        (load),
        .burst       (cmd.burst),
        .addr_done   (addr_done),
        .data_busy   (data_busy),
        .hready      (hready),
        .last_beat   (last_beat),
        .timed_out   (timed_out)
    );

    ahb_addr_gen i_addr_gen (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .cmd         (cmd),
        .load        (load),
        .advance     (advance),
        .go_idle     (go_idle),
        .hready      (hready),
        .ctrl        (ctrl)
    );

    ahb_data_path i_data_path (
        .ahb_clk_in    (ahb_clk_in),
        .ahb_rstn_in   (ahb_rstn_in),
        .wdata         (wdata),
        .phase_done    (phase_done),
        .write         (ctrl.hwrite),
        .hrdata        (hrdata),
        .hready        (hready),
        .hresp         (hresp),
        .abort_err     (abort_err),
        .abort_timeout (abort_timeout),
        .reject        (reject),
        .hwdata        (hwdata),
        .rsp           (rsp),
        .rsp_valid     (rsp_valid)
    );

endmodule

// File: logic/ahb_data_path.sv
`timescale 1ns/1ns
// write data staging for the data phase, read data capture and client responses
module ahb_data_path import ahb_master_pkg::*; (
    input  logic     ahb_clk_in,
    input  logic     ahb_rstn_in,
    input  data_t    wdata,
    input  logic     phase_done,
    input  logic     write,
    input  data_t    hrdata,
    input  logic     hready,
    input  logic     hresp,
    input  logic     abort_err,
    input  logic     abort_timeout,
    input  logic     reject,
    output data_t    hwdata,
    output ahb_rsp_t rsp,
    output logic     rsp_valid
);
    logic pend;
    logic phase_end;

    // a data phase is pending from its address phase until HREADY is seen high
    assign phase_end = pend && hready;

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            pend      <= 1'b0;
            rsp_valid <= 1'b0;
            hwdata    <= '0;
        end else begin
            rsp_valid <= phase_end || abort_timeout || reject;
            if (abort_timeout) begin
                pend <= 1'b0;
            end else if (hready) begin
                pend <= phase_done;
            end
            if (phase_done && write) begin
                hwdata <= wdata;
            end else if (abort_err || abort_timeout) begin
                hwdata <= '0;
            end
        end
    end

    always_ff @(posedge ahb_clk_in) begin
        if (phase_end) begin
            rsp <= '{rdata: hrdata, error: hresp, timeout: 1'b0};
        end else if (abort_timeout) begin
            rsp <= '{rdata: '0, error: 1'b1, timeout: 1'b1};
        end else if (reject) begin
            rsp <= '{rdata: '0, error: 1'b1, timeout: 1'b0};
        end
    end

endmodule

// File: logic/ahb_addr_gen.sv
`timescale 1ns/1ns
// address-phase control register with incrementing and wrapping beat address generation
module ahb_addr_gen import ahb_master_pkg::*; (
    input  logic      ahb_clk_in,
    input  logic      ahb_rstn_in,
    input  ahb_cmd_t  cmd,
    input  logic      load,
    input  logic      advance,
    input  logic      go_idle,
    input  logic      hready,
    output ahb_ctrl_t ctrl
);
    addr_t size_bytes;
    addr_t incr_addr;
    addr_t wrap_mask;
    addr_t wrap_addr;
    addr_t next_addr;

    assign size_bytes = addr_t'(1) << ctrl.hsize;
    assign incr_addr  = ctrl.haddr + size_bytes;

    // the wrap block is beats times size bytes, aligned to its own size
    assign wrap_mask = (addr_t'(burst_beats(ctrl.hburst)) << ctrl.hsize) - 1'b1;
    assign wrap_addr = (ctrl.haddr & ~wrap_mask) | (incr_addr & wrap_mask);
    assign next_addr = burst_is_wrap(ctrl.hburst) ? wrap_addr : incr_addr;

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            ctrl <= '0;
        end else if (load) begin
            ctrl <= '{
                haddr:  cmd.addr,
                htrans: TRANS_NONSEQ,
                hburst: cmd.burst,
                hsize:  cmd.size,
                hwrite: cmd.write
            };
        end else if (go_idle) begin
            ctrl.htrans <= TRANS_IDLE;
        end else if (advance && hready) begin
            // while the slave holds HREADY low the address phase stays on the bus
            ctrl.haddr  <= next_addr;
            ctrl.htrans <= TRANS_SEQ;
        end
    end

endmodule

// File: logic/ahb_beat_counter.sv
`timescale 1ns/1ns
// remaining-beat counter and HREADY wait timeout for the current burst
module ahb_beat_counter import ahb_master_pkg::*; (
    input  logic   ahb_clk_in,
    input  logic   ahb_rstn_in,
    input  logic   load,
    input  burst_e burst,
    input  logic   addr_done,
    input  logic   data_busy,
    input  logic   hready,
    output logic   last_beat,
    output logic   timed_out
);
    beats_t remain;
    wait_t  wait_cnt;

    // remain includes the beat whose address phase is on the bus
    assign last_beat = (remain == beats_t'(1));

    // raised in the cycle that would be the WAIT_TIMEOUT-th low HREADY of one data phase
    assign timed_out = data_busy && !hready && (wait_cnt == wait_t'(WAIT_TIMEOUT - 1));

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            remain <= '0;
        end else if (load) begin
            remain <= burst_beats(burst);
        end else if (addr_done && (remain != '0)) begin
            remain <= remain - 1'b1;
        end
    end

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            wait_cnt <= '0;
        end else if (!data_busy || hready) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

endmodule

// File: logic/ahb_master_fsm.sv
`timescale 1ns/1ns
// transfer sequencing FSM that accepts commands, issues beats and decides aborts
module ahb_master_fsm import ahb_master_pkg::*; (
    input  logic   ahb_clk_in,
    input  logic   ahb_rstn_in,
    input  logic   cmd_valid,
    input  logic   cmd_ok,
    input  logic   hready,
    input  logic   hresp,
    input  trans_e htrans,
    input  logic   last_beat,
    input  logic   timed_out,
    output logic   cmd_ready,
    output logic   beat_pop,
    output logic   load,
    output logic   advance,
    output logic   go_idle,
    output logic   addr_done,
    output logic   data_busy,
    output logic   phase_done,
    output logic   abort_err,
    output logic   abort_timeout,
    output logic   reject
);
    state_e state;
    state_e state_next;
    logic   addr_ok;
    logic   phase_ok;

    assign addr_ok = ((htrans == TRANS_NONSEQ) || (htrans == TRANS_SEQ)) && hready;

    // an error ends the outstanding data phase and cancels the beat issued alongside it
    assign abort_err     = data_busy && hready && hresp;
    assign abort_timeout = timed_out && (state != ST_IDLE);
    assign phase_ok      = addr_ok && !abort_err;

    assign beat_pop   = phase_ok;
    assign addr_done  = phase_ok;
    assign phase_done = phase_ok;

    assign cmd_ready = (state == ST_IDLE);
    assign load      = cmd_ready && cmd_valid && cmd_ok;
    assign reject    = cmd_ready && cmd_valid && !cmd_ok;
    assign advance   = (state == ST_ADDR) && !last_beat && !abort_err;
    assign go_idle   = abort_err || abort_timeout || ((state == ST_ADDR) && phase_ok && last_beat);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (cmd_valid) begin
                    state_next = cmd_ok ? ST_ADDR : ST_ERROR;
                end
            end
            ST_ADDR: begin
                if (abort_err || abort_timeout) begin
                    state_next = ST_IDLE;
                end else if (phase_ok && last_beat) begin
                    state_next = ST_WAIT_LAST;
                end
            end
            ST_WAIT_LAST: begin
                // the last data phase ends on hready, with or without an error
                if (abort_timeout || (data_busy && hready)) begin
                    state_next = ST_IDLE;
                end
            end
            ST_ERROR: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            state     <= ST_IDLE;
            data_busy <= 1'b0;
        end else begin
            state <= state_next;
            if (abort_err || abort_timeout) begin
                data_busy <= 1'b0;
            end else if (hready) begin
                data_busy <= phase_ok;
            end
        end
    end

endmodule

// File: logic/ahb_req_check.sv
`timescale 1ns/1ns
// client command check for supported burst, transfer size, alignment and 1 KB boundary
module ahb_req_check import ahb_master_pkg::*; (
    input  ahb_cmd_t cmd,
    output logic     cmd_ok
);
    addr_t size_bytes;
    addr_t last_addr;
    logic  burst_ok;
    logic  size_ok;
    logic  align_ok;
    logic  bound_ok;

    assign size_bytes = addr_t'(1) << cmd.size;
    assign last_addr  = cmd.addr + ((addr_t'(burst_beats(cmd.burst)) - 1'b1) << cmd.size);

    // undefined-length INCR is not supported by this master
    assign burst_ok = (cmd.burst != BURST_INCR);
    assign size_ok  = ((8 << cmd.size) <= DATA_WIDTH);
    assign align_ok = ((cmd.addr & (size_bytes - 1'b1)) == '0);

    // a wrapping burst stays inside its own aligned block, so only incrementing ones can cross
    assign bound_ok = burst_is_wrap(cmd.burst) ||
                      (last_addr[ADDR_WIDTH-1:BOUNDARY_BITS] ==
                       cmd.addr[ADDR_WIDTH-1:BOUNDARY_BITS]);

    assign cmd_ok = burst_ok && size_ok && align_ok && bound_ok;

endmodule

// File: logic/ahb_master_pkg.sv
// AHB-Lite master shared types: bus widths, AHB encodings, FSM states and command structs
package ahb_master_pkg;

    localparam int ADDR_WIDTH    = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int WAIT_TIMEOUT  = 6;
    localparam int BOUNDARY_BITS = 10;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [4:0]            beats_t;
    typedef logic [2:0]            wait_t;

    typedef enum logic [2:0] {
        BURST_SINGLE = 3'd0,
        BURST_INCR   = 3'd1,
        BURST_WRAP4  = 3'd2,
        BURST_INCR4  = 3'd3,
        BURST_WRAP8  = 3'd4,
        BURST_INCR8  = 3'd5,
        BURST_WRAP16 = 3'd6,
        BURST_INCR16 = 3'd7
    } burst_e;

    typedef enum logic [1:0] {
        TRANS_IDLE   = 2'd0,
        TRANS_BUSY   = 2'd1,
        TRANS_NONSEQ = 2'd2,
        TRANS_SEQ    = 2'd3
    } trans_e;

    typedef enum logic [2:0] {
        SIZE_BYTE = 3'd0,
        SIZE_HALF = 3'd1,
        SIZE_WORD = 3'd2
    } size_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_ADDR      = 2'd1,
        ST_WAIT_LAST = 2'd2,
        ST_ERROR     = 2'd3
    } state_e;

    typedef struct packed {
        addr_t  addr;
        burst_e burst;
        size_e  size;
        logic   write;
    } ahb_cmd_t;

    typedef struct packed {
        addr_t  haddr;
        trans_e htrans;
        burst_e hburst;
        size_e  hsize;
        logic   hwrite;
    } ahb_ctrl_t;

    typedef struct packed {
        data_t rdata;
        logic  error;
        logic  timeout;
    } ahb_rsp_t;

    // number of beats in a fixed-length burst, single transfers count as one
    function automatic beats_t burst_beats(burst_e burst);
        case (burst)
            BURST_WRAP4, BURST_INCR4:   return beats_t'(4);
            BURST_WRAP8, BURST_INCR8:   return beats_t'(8);
            BURST_WRAP16, BURST_INCR16: return beats_t'(16);
            default:                    return beats_t'(1);
        endcase
    endfunction

    function automatic logic burst_is_wrap(burst_e burst);
        return (burst == BURST_WRAP4) || (burst == BURST_WRAP8) || (burst == BURST_WRAP16);
    endfunction

endpackage
